// File: hdl/rx_cfg_pkg.sv
package rx_cfg_pkg;

    // bus and counter widths
    localparam int BUS_ADDR_W  = 16;
    localparam int FIFO_SIZE_W = 16;
    localparam int CNT_W       = 8;

    localparam logic [7:0] RX_VERSION = 8'd3;

    // register map
    localparam logic [BUS_ADDR_W-1:0] REG_SOFT_RST     = 16'd0;  // write: soft reset, read: version
    localparam logic [BUS_ADDR_W-1:0] REG_RX_RST       = 16'd1;
    localparam logic [BUS_ADDR_W-1:0] REG_STATUS       = 16'd2;
    localparam logic [BUS_ADDR_W-1:0] REG_FIFO_SIZE_LO = 16'd3;
    localparam logic [BUS_ADDR_W-1:0] REG_FIFO_SIZE_HI = 16'd4;  // latched by the low byte read
    localparam logic [BUS_ADDR_W-1:0] REG_DEC_ERR_CNT  = 16'd5;
    localparam logic [BUS_ADDR_W-1:0] REG_LOST_CNT     = 16'd6;

    // control characters on the link
    localparam logic [7:0] K_IDLE = 8'h3C;  // K28.1
    localparam logic [7:0] K_SOF  = 8'hFC;  // K28.7
    localparam logic [7:0] K_EOF  = 8'hBC;  // K28.5

endpackage

// File: hdl/rx_data_pkg.sv
package rx_data_pkg;

    // one decoded code group
    typedef struct packed {
        logic [7:0] data;      // zero when code_err is set
        logic       is_k;      // K28.1, K28.5 or K28.7
        logic       code_err;  // group not in the code tables
    } rx_symbol_t;

    // one FIFO word
    typedef struct packed {
        logic [7:0]  identifier;
        logic [23:0] payload;     // first received byte in [23:16]
    } rx_record_t;

endpackage

// File: hdl/rx_symbol_aligner.sv
module rx_symbol_aligner #(
    parameter int SYNC_COMMAS = 4
) (
    input  logic       BUS_CLK,
    input  logic       RST_FLAG,
    input  logic       rx_rst,
    input  logic       rx_data,
    input  logic       cfg_invert,
    output logic [9:0] sym_code,
    output logic       sym_strobe,
    output logic       sync_ready
);

    localparam int CW = $clog2(SYNC_COMMAS + 1);

    logic          rst;
    logic          rx_bit;
    logic [9:0]    shift_reg;
    logic [9:0]    win_next;
    logic [3:0]    pos;        // position of the incoming bit in its group
    logic          comma_det;
    logic [CW-1:0] comma_cnt;
    logic [CW-1:0] cnt_base;

    assign rst      = RST_FLAG | rx_rst;
    assign rx_bit   = rx_data ^ cfg_invert;
    assign win_next = {shift_reg[8:0], rx_bit};  // bit a lands in [9]

    // comma sits in abcdeif of a group
    assign comma_det = (win_next[9:3] == 7'b0011111) || (win_next[9:3] == 7'b1100000);

    // comma on the present boundary extends the run, anywhere else starts a new one
    assign cnt_base = (pos == 4'd9) ? comma_cnt : '0;

    always_ff @(posedge BUS_CLK) begin
        shift_reg <= win_next;
        sym_code  <= win_next;  // qualified by sym_strobe
    end

    always_ff @(posedge BUS_CLK) begin
        if (rst) begin
            pos        <= 4'd0;
            comma_cnt  <= '0;
            sync_ready <= 1'b0;
            sym_strobe <= 1'b0;
        end else begin
            pos        <= (pos == 4'd9) ? 4'd0 : pos + 4'd1;
            sym_strobe <= sync_ready && (pos == 4'd9);
            if (!sync_ready) begin
                if (comma_det) begin
                    pos <= 4'd0;  // next bit opens a group
                    if (cnt_base == CW'(SYNC_COMMAS - 1))
                        sync_ready <= 1'b1;
                    else
                        comma_cnt <= cnt_base + 1'b1;
                end else if (pos == 4'd9) begin
                    comma_cnt <= '0;  // run broken
                end
            end
        end
    end

endmodule

// File: hdl/rx_8b10b_decoder.sv
module rx_8b10b_decoder import rx_cfg_pkg::*, rx_data_pkg::*; (
    input  logic       BUS_CLK,
    input  logic       RST_FLAG,
    input  logic [9:0] sym_code,
    input  logic       sym_strobe,
    output rx_symbol_t dec_symbol,
    output logic       dec_strobe
);

    logic [5:0] abcdei;
    logic [3:0] fghj;
    logic [4:0] edcba;
    logic [2:0] hgf;
    logic       err_6b;
    logic       err_4b;
    logic       k28;
    logic [7:0] byte_val;
    logic       is_ctrl;
    logic       bad;

    assign abcdei = sym_code[9:4];
    assign k28    = (abcdei == 6'b001111) || (abcdei == 6'b110000);

    // after 110000 the K28 4b block comes complemented
    assign fghj = (abcdei == 6'b110000) ? ~sym_code[3:0] : sym_code[3:0];

    always_comb begin
        err_6b = 1'b0;
        case (abcdei)
            6'b100111, 6'b011000: edcba = 5'd0;
            6'b011101, 6'b100010: edcba = 5'd1;
            6'b101101, 6'b010010: edcba = 5'd2;
            6'b110001:            edcba = 5'd3;
            6'b110101, 6'b001010: edcba = 5'd4;
            6'b101001:            edcba = 5'd5;
            6'b011001:            edcba = 5'd6;
            6'b111000, 6'b000111: edcba = 5'd7;
            6'b111001, 6'b000110: edcba = 5'd8;
            6'b100101:            edcba = 5'd9;
            6'b010101:            edcba = 5'd10;
            6'b110100:            edcba = 5'd11;
            6'b001101:            edcba = 5'd12;
            6'b101100:            edcba = 5'd13;
            6'b011100:            edcba = 5'd14;
            6'b010111, 6'b101000: edcba = 5'd15;
            6'b011011, 6'b100100: edcba = 5'd16;
            6'b100011:            edcba = 5'd17;
            6'b010011:            edcba = 5'd18;
            6'b110010:            edcba = 5'd19;
            6'b001011:            edcba = 5'd20;
            6'b101010:            edcba = 5'd21;
            6'b011010:            edcba = 5'd22;
            6'b111010, 6'b000101: edcba = 5'd23;
            6'b110011, 6'b001100: edcba = 5'd24;
            6'b100110:            edcba = 5'd25;
            6'b010110:            edcba = 5'd26;
            6'b110110, 6'b001001: edcba = 5'd27;
            6'b001110:            edcba = 5'd28;
            6'b101110, 6'b010001: edcba = 5'd29;
            6'b011110, 6'b100001: edcba = 5'd30;
            6'b101011, 6'b010100: edcba = 5'd31;
            6'b001111, 6'b110000: edcba = 5'd28;  // K28
            default: begin
                edcba  = 5'd0;
                err_6b = 1'b1;
            end
        endcase
    end

    always_comb begin
        err_4b = 1'b0;
        case (fghj)
            4'b1011, 4'b0100:                   hgf = 3'd0;
            4'b1001:                            hgf = 3'd1;
            4'b0101:                            hgf = 3'd2;
            4'b1100, 4'b0011:                   hgf = 3'd3;
            4'b1101, 4'b0010:                   hgf = 3'd4;
            4'b1010:                            hgf = 3'd5;
            4'b0110:                            hgf = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: hgf = 3'd7;  // primary and alternate
            default: begin
                hgf    = 3'd0;
                err_4b = 1'b1;
            end
        endcase
    end

    assign byte_val = {hgf, edcba};
    assign is_ctrl  = k28 && (byte_val inside {K_IDLE, K_SOF, K_EOF});
    assign bad      = err_6b || err_4b || (k28 && !is_ctrl);  // other K28.x unsupported

    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG)
            dec_strobe <= 1'b0;
        else
            dec_strobe <= sym_strobe;
    end

    always_ff @(posedge BUS_CLK) begin
        if (sym_strobe) begin
            dec_symbol.data     <= bad ? 8'd0 : byte_val;
            dec_symbol.is_k     <= is_ctrl && !bad;
            dec_symbol.code_err <= bad;
        end
    end

endmodule

// File: hdl/rx_record_packer.sv
module rx_record_packer import rx_cfg_pkg::*, rx_data_pkg::*; #(
    parameter logic [7:0] DATA_IDENTIFIER = 8'd0
) (
    input  logic             BUS_CLK,
    input  logic             RST_FLAG,
    input  logic             rx_rst,
    input  logic             cfg_enable,
    input  rx_symbol_t       dec_symbol,
    input  logic             dec_strobe,
    input  logic             fifo_full,
    output logic             wr_en,
    output rx_record_t       wr_record,
    output logic [CNT_W-1:0] dec_err_cnt,
    output logic [CNT_W-1:0] lost_cnt
);

    logic        rst;
    logic        in_frame;
    logic [1:0]  byte_idx;
    logic [15:0] asm_reg;   // bytes 0 and 1 of the record in progress
    logic        collect;
    logic        rec_done;

    assign rst      = RST_FLAG | rx_rst;
    assign collect  = dec_strobe && cfg_enable && in_frame
                      && !dec_symbol.is_k && !dec_symbol.code_err;
    assign rec_done = collect && (byte_idx == 2'd2);

    always_ff @(posedge BUS_CLK) begin
        if (collect)
            asm_reg <= {asm_reg[7:0], dec_symbol.data};
        if (rec_done) begin
            wr_record.identifier <= DATA_IDENTIFIER;
            wr_record.payload    <= {asm_reg, dec_symbol.data};
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (rst) begin
            in_frame    <= 1'b0;
            byte_idx    <= 2'd0;
            wr_en       <= 1'b0;
            dec_err_cnt <= '0;
            lost_cnt    <= '0;
        end else begin
            wr_en <= rec_done && !fifo_full;
            if (rec_done && fifo_full && lost_cnt != '1)
                lost_cnt <= lost_cnt + 1'b1;

            if (!cfg_enable) begin
                in_frame <= 1'b0;
                byte_idx <= 2'd0;
            end else if (dec_strobe) begin
                if (dec_symbol.code_err) begin
                    in_frame <= 1'b0;  // partial record dropped
                    byte_idx <= 2'd0;
                    if (dec_err_cnt != '1)
                        dec_err_cnt <= dec_err_cnt + 1'b1;
                end else if (dec_symbol.is_k) begin
                    if (dec_symbol.data == K_SOF) begin
                        in_frame <= 1'b1;
                        byte_idx <= 2'd0;
                    end else if (dec_symbol.data == K_EOF) begin
                        in_frame <= 1'b0;
                        byte_idx <= 2'd0;
                    end
                end else if (in_frame) begin
                    byte_idx <= (byte_idx == 2'd2) ? 2'd0 : byte_idx + 2'd1;
                end
            end
        end
    end

endmodule

// File: hdl/rx_record_fifo.sv
module rx_record_fifo import rx_cfg_pkg::*, rx_data_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   BUS_CLK,
    input  logic                   RST_FLAG,
    input  logic                   rx_rst,
    input  logic                   wr_en,
    input  rx_record_t             wr_record,
    input  logic                   fifo_read,
    output rx_record_t             fifo_data,
    output logic                   fifo_empty,
    output logic                   fifo_full,
    output logic [FIFO_SIZE_W-1:0] fifo_size
);

    localparam int AW = $clog2(FIFO_DEPTH);

    rx_record_t    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == (AW+1)'(FIFO_DEPTH));
    assign fifo_size  = FIFO_SIZE_W'(count);
    assign fifo_data  = mem[rd_ptr];  // head word shown without a read

    assign do_rd = fifo_read && !fifo_empty;
    assign do_wr = wr_en && (!fifo_full || do_rd);

    always_ff @(posedge BUS_CLK) begin
        if (do_wr)
            mem[wr_ptr] <= wr_record;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG || rx_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps by itself
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

endmodule

// File: hdl/rx_bus_regs.sv
module rx_bus_regs import rx_cfg_pkg::*; (
    input  logic                   BUS_CLK,
    input  logic                   RST_FLAG,
    input  logic [BUS_ADDR_W-1:0]  bus_add,
    input  logic [7:0]             bus_data_in,
    input  logic                   bus_wr,
    input  logic                   bus_rd,
    output logic [7:0]             bus_data_out,
    input  logic                   sync_ready,
    input  logic [FIFO_SIZE_W-1:0] fifo_size,
    input  logic [CNT_W-1:0]       dec_err_cnt,
    input  logic [CNT_W-1:0]       lost_cnt,
    output logic                   cfg_invert,
    output logic                   cfg_enable,
    output logic                   rx_rst
);

    logic       soft_rst;
    logic [7:1] status_reg;  // bit 0 reads the sync level instead
    logic [7:0] size_hi;

    assign cfg_invert = status_reg[1];
    assign cfg_enable = status_reg[2];

    // one-cycle reset pulses from register writes
    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG) begin
            soft_rst <= 1'b0;
            rx_rst   <= 1'b0;
        end else begin
            soft_rst <= bus_wr && (bus_add == REG_SOFT_RST);
            rx_rst   <= bus_wr && (bus_add == REG_SOFT_RST || bus_add == REG_RX_RST);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST_FLAG || soft_rst)
            status_reg <= '0;  // receiver disabled
        else if (bus_wr && bus_add == REG_STATUS)
            status_reg <= bus_data_in[7:1];
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus_rd && bus_add == REG_FIFO_SIZE_LO)
            size_hi <= fifo_size[15:8];  // keeps both bytes from one sample
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus_rd) begin
            case (bus_add)
                REG_SOFT_RST:     bus_data_out <= RX_VERSION;
                REG_STATUS:       bus_data_out <= {status_reg, sync_ready};
                REG_FIFO_SIZE_LO: bus_data_out <= fifo_size[7:0];
                REG_FIFO_SIZE_HI: bus_data_out <= size_hi;
                REG_DEC_ERR_CNT:  bus_data_out <= dec_err_cnt;
                REG_LOST_CNT:     bus_data_out <= lost_cnt;
                default:          bus_data_out <= 8'd0;
            endcase
        end
    end

endmodule

// File: hdl/fei4_rx_top.sv
module fei4_rx_top import rx_cfg_pkg::*, rx_data_pkg::*; #(
    parameter logic [7:0] DATA_IDENTIFIER = 8'd0,
    parameter int         FIFO_DEPTH      = 16,
    parameter int         SYNC_COMMAS     = 4
) (
    input  logic                  BUS_CLK,
    input  logic                  RST_FLAG,
    input  logic                  rx_data,
    input  logic [BUS_ADDR_W-1:0] bus_add,
    input  logic [7:0]            bus_data_in,
    input  logic                  bus_wr,
    input  logic                  bus_rd,
    output logic [7:0]            bus_data_out,
    input  logic                  fifo_read,
    output logic                  fifo_empty,
    output rx_record_t            fifo_data,
    output logic                  rx_ready
);

    logic                   cfg_invert;
    logic                   cfg_enable;
    logic                   rx_rst;
    logic [9:0]             sym_code;
    logic                   sym_strobe;
    rx_symbol_t             dec_symbol;
    logic                   dec_strobe;
    logic                   wr_en;
    rx_record_t             wr_record;
    logic                   fifo_full;
    logic [FIFO_SIZE_W-1:0] fifo_size;
    logic [CNT_W-1:0]       dec_err_cnt;
    logic [CNT_W-1:0]       lost_cnt;

    rx_bus_regs rx_bus_regs_inst (
        .BUS_CLK      (BUS_CLK),
        .RST_FLAG     (RST_FLAG),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .sync_ready   (rx_ready),
        .fifo_size    (fifo_size),
        .dec_err_cnt  (dec_err_cnt),
        .lost_cnt     (lost_cnt),
        .cfg_invert   (cfg_invert),
        .cfg_enable   (cfg_enable),
        .rx_rst       (rx_rst)
    );

    rx_symbol_aligner #(
        .SYNC_COMMAS (SYNC_COMMAS)
    ) rx_symbol_aligner_inst (
        .BUS_CLK    (BUS_CLK),
        .RST_FLAG   (RST_FLAG),
        .rx_rst     (rx_rst),
        .rx_data    (rx_data),
        .cfg_invert (cfg_invert),
        .sym_code   (sym_code),
        .sym_strobe (sym_strobe),
        .sync_ready (rx_ready)
    );

    rx_8b10b_decoder rx_8b10b_decoder_inst (
        .BUS_CLK    (BUS_CLK),
        .RST_FLAG   (RST_FLAG),
        .sym_code   (sym_code),
        .sym_strobe (sym_strobe),
        .dec_symbol (dec_symbol),
        .dec_strobe (dec_strobe)
    );

    rx_record_packer #(
        .DATA_IDENTIFIER (DATA_IDENTIFIER)
    ) rx_record_packer_inst (
        .BUS_CLK     (BUS_CLK),
        .RST_FLAG    (RST_FLAG),
        .rx_rst      (rx_rst),
        .cfg_enable  (cfg_enable),
        .dec_symbol  (dec_symbol),
        .dec_strobe  (dec_strobe),
        .fifo_full   (fifo_full),
        .wr_en       (wr_en),
        .wr_record   (wr_record),
        .dec_err_cnt (dec_err_cnt),
        .lost_cnt    (lost_cnt)
    );

    rx_record_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rx_record_fifo_inst (
        .BUS_CLK    (BUS_CLK),
        .RST_FLAG   (RST_FLAG),
        .rx_rst     (rx_rst),
        .wr_en      (wr_en),
        .wr_record  (wr_record),
        .fifo_read  (fifo_read),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .fifo_size  (fifo_size)
    );

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic BUS_CLK,
    output logic RST_FLAG
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        BUS_CLK = 1'b0;
        forever #2 BUS_CLK = ~BUS_CLK;  // 4 ns period
    end

    // reset held over the first two rising edges
    initial begin
        RST_FLAG = 1'b1;
        repeat (2) @(posedge BUS_CLK);
        RST_FLAG <= 1'b0;
    end

endmodule

// File: sim/tb_fei4_rx.sv
module tb_fei4_rx import rx_cfg_pkg::*, rx_data_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [7:0] TB_ID = 8'hA5;

    logic                  BUS_CLK;
    logic                  RST_FLAG;
    logic                  rx_data;
    logic [BUS_ADDR_W-1:0] bus_add;
    logic [7:0]            bus_data_in;
    logic                  bus_wr;
    logic                  bus_rd;
    logic [7:0]            bus_data_out;
    logic                  fifo_read;
    logic                  fifo_empty;
    rx_record_t            fifo_data;
    logic                  rx_ready;

    logic [9:0]  tx_queue [$];   // {invalid, is_k, byte}
    rx_record_t  exp_queue [$];
    logic        link_on;
    logic        link_inv;
    logic        tx_rd;          // high while the running disparity is positive
    logic        reader_on;
    logic [31:0] lfsr_state;
    string       test_name;

    tb_clock_gen tb_clock_gen_inst (
        .BUS_CLK  (BUS_CLK),
        .RST_FLAG (RST_FLAG)
    );

    fei4_rx_top #(
        .DATA_IDENTIFIER (TB_ID),
        .FIFO_DEPTH      (16)
    ) fei4_rx_top_inst (
        .BUS_CLK      (BUS_CLK),
        .RST_FLAG     (RST_FLAG),
        .rx_data      (rx_data),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data),
        .rx_ready     (rx_ready)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    // expected FIFO word with the first byte on top
    function automatic rx_record_t make_record(input logic [7:0] id, input logic [7:0] b0,
                                               input logic [7:0] b1, input logic [7:0] b2);
        rx_record_t r;
        r.identifier = id;
        r.payload    = {b0, b1, b2};
        return r;
    endfunction

    // 5b/6b and 3b/4b codes for negative running disparity
    function automatic logic [5:0] code_6b(input logic [4:0] x);
        logic [5:0] t [32];
        t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001,
              6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100,
              6'b011100, 6'b010111, 6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011,
              6'b101010, 6'b011010, 6'b111010, 6'b110011, 6'b100110, 6'b010110, 6'b110110,
              6'b001110, 6'b101110, 6'b011110, 6'b101011};
        return t[x];
    endfunction

    function automatic logic [3:0] code_4b(input logic [2:0] y);
        logic [3:0] t [8];
        t = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
        return t[y];
    endfunction

    // returns the new running disparity on top of abcdeifghj
    function automatic logic [10:0] encode_symbol(input logic [7:0] b, input logic is_k,
                                                  input logic rd_pos);
        logic [5:0] c6;
        logic [3:0] c4;
        logic [9:0] code;
        logic       rd;
        if (is_k) begin
            case (b[7:5])
                3'd1:    code = 10'b0011111001;
                3'd5:    code = 10'b0011111010;
                default: code = 10'b0011111000;  // K28.7
            endcase
            if (rd_pos)
                code = ~code;
            return {rd_pos ^ ($countones(code) != 5), code};
        end
        c6 = code_6b(b[4:0]);
        if (rd_pos && ($countones(c6) != 3 || b[4:0] == 5'd7))
            c6 = ~c6;
        rd = rd_pos ^ ($countones(c6) != 3);
        c4 = code_4b(b[7:5]);
        if (b[7:5] == 3'd7 && ((!rd && b[4:0] inside {5'd17, 5'd18, 5'd20})
                               || (rd && b[4:0] inside {5'd11, 5'd13, 5'd14})))
            c4 = 4'b0111;  // alternate D.x.7 avoids a run of five
        if (rd && ($countones(c4) != 2 || b[7:5] == 3'd3))
            c4 = ~c4;
        rd = rd ^ ($countones(c4) != 2);
        return {rd, c6, c4};
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_record(input string name, input rx_record_t exp, input rx_record_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_reg(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_on_error($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr      <= 1'b0;
    endtask

    // data shows up the cycle after bus_rd is sampled
    task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd  <= 1'b0;
        @(posedge BUS_CLK);
        data = bus_data_out;
    endtask

    task automatic check_read(input string what, input logic [BUS_ADDR_W-1:0] addr,
                              input logic [7:0] exp);
        logic [7:0] val;
        bus_read(addr, val);
        check_reg({test_name, " ", what}, exp, val);
    endtask

    task automatic wait_ready(input logic level, input int limit);
        int n;
        n = 0;
        while (rx_ready !== level) begin
            @(posedge BUS_CLK);
            n++;
            if (n > limit)
                stop_on_error($sformatf("timeout in %s: rx_ready never reached %0d",
                                        test_name, level));
        end
    endtask

    task automatic wait_expected_drained(input int limit);
        int n;
        n = 0;
        while (exp_queue.size() != 0 || !fifo_empty) begin
            @(posedge BUS_CLK);
            n++;
            if (n > limit)
                stop_on_error($sformatf("timeout in %s: %0d expected records never arrived",
                                        test_name, exp_queue.size()));
        end
    endtask

    // waits for the queue to empty and the last group to pass the pipeline
    task automatic wait_link_drain(input int limit);
        int n;
        n = 0;
        while (tx_queue.size() != 0) begin
            @(posedge BUS_CLK);
            n++;
            if (n > limit)
                stop_on_error($sformatf("timeout in %s: serial link never went idle",
                                        test_name));
        end
        repeat (24) @(posedge BUS_CLK);
    endtask

    task automatic send_frame(input int n, input logic expect_rec);
        logic [7:0]  v;
        logic [23:0] acc;
        acc = '0;
        tx_queue.push_back({2'b01, K_SOF});
        for (int i = 0; i < n; i++) begin
            take_bits(8, v);
            tx_queue.push_back({2'b00, v});
            acc = {acc[15:0], v};
            if (i % 3 == 2 && expect_rec)
                exp_queue.push_back(make_record(TB_ID, acc[23:16], acc[15:8], acc[7:0]));
        end
        tx_queue.push_back({2'b01, K_EOF});
    endtask

    task automatic send_random_frames(input int frames);
        logic [7:0] v;
        for (int f = 0; f < frames; f++) begin
            take_bits(4, v);
            send_frame(3 + v % 10, 1'b1);  // trailing partial bytes give no word
        end
    endtask

    // idles fill the gaps so the link never stops
    initial begin : serializer
        logic [9:0]  item;
        logic [10:0] enc;
        logic [9:0]  code;
        rx_data  = 1'b0;
        tx_rd    = 1'b0;
        link_on  = 1'b0;
        link_inv = 1'b0;
        forever begin
            if (!link_on) begin
                @(posedge BUS_CLK);
                rx_data <= 1'b0;
            end else begin
                if (tx_queue.size() > 0)
                    item = tx_queue.pop_front();
                else
                    item = {2'b01, K_IDLE};
                if (item[9]) begin
                    code = 10'b1111111111;  // not a code group
                end else begin
                    enc   = encode_symbol(item[7:0], item[8], tx_rd);
                    tx_rd = enc[10];
                    code  = enc[9:0];
                end
                for (int i = 9; i >= 0; i--) begin
                    @(posedge BUS_CLK);
                    rx_data <= code[i] ^ link_inv;  // bit a first
                end
            end
        end
    end

    // pops every other cycle at most and compares in order
    initial begin : reader
        rx_record_t exp;
        fifo_read = 1'b0;
        forever begin
            @(posedge BUS_CLK);
            if (reader_on && !fifo_empty && !fifo_read) begin
                if (exp_queue.size() == 0) begin
                    stop_on_error($sformatf("%s: FIFO word %h arrived with none expected",
                                            test_name, fifo_data));
                end else begin
                    exp = exp_queue.pop_front();
                    check_record({test_name, " record"}, exp, fifo_data);
                    fifo_read <= 1'b1;
                end
            end else begin
                fifo_read <= 1'b0;
            end
        end
    end

    initial begin : sequencer
        int n;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        reader_on   = 1'b1;
        lfsr_state  = 32'h3f3b;
        test_name   = "reset";

        n = 0;
        while (RST_FLAG !== 1'b0) begin
            @(posedge BUS_CLK);
            n++;
            if (n > 20)
                stop_on_error("timeout: reset was never released");
        end

        test_name = "defaults";
        check_read("status", REG_STATUS, 8'h00);
        check_read("version", REG_SOFT_RST, 8'h03);
        check_read("fill lo", REG_FIFO_SIZE_LO, 8'h00);
        check_read("fill hi", REG_FIFO_SIZE_HI, 8'h00);
        check_read("dec err", REG_DEC_ERR_CNT, 8'h00);
        check_read("lost", REG_LOST_CNT, 8'h00);
        check_reg("defaults fifo_empty", 8'h01, {7'd0, fifo_empty});

        test_name = "lock_and_data";
        link_on   <= 1'b1;
        bus_write(REG_STATUS, 8'h04);
        wait_ready(1'b1, 2000);
        send_random_frames(6);
        wait_expected_drained(20000);
        wait_link_drain(20000);

        test_name = "inverted_link";
        link_inv  <= 1'b1;
        bus_write(REG_STATUS, 8'h06);
        bus_write(REG_RX_RST, 8'h00);  // relock on the inverted stream
        wait_ready(1'b0, 20);
        wait_ready(1'b1, 2000);
        send_random_frames(6);
        wait_expected_drained(20000);
        wait_link_drain(20000);

        test_name = "disabled";
        bus_write(REG_STATUS, 8'h02);
        send_frame(9, 1'b0);
        send_frame(6, 1'b0);
        wait_link_drain(5000);
        check_read("status", REG_STATUS, 8'h03);
        check_read("fill lo", REG_FIFO_SIZE_LO, 8'h00);
        check_reg("disabled fifo_empty", 8'h01, {7'd0, fifo_empty});

        test_name = "code_error";
        bus_write(REG_STATUS, 8'h06);
        tx_queue.push_back({2'b01, K_SOF});
        tx_queue.push_back({2'b00, 8'h11});
        tx_queue.push_back({2'b00, 8'h22});
        tx_queue.push_back(10'h200);
        tx_queue.push_back({2'b00, 8'h33});
        tx_queue.push_back({2'b01, K_EOF});
        wait_link_drain(5000);
        check_read("dec err", REG_DEC_ERR_CNT, 8'h01);
        check_read("fill lo", REG_FIFO_SIZE_LO, 8'h00);

        test_name = "overflow";
        reader_on <= 1'b0;
        for (int i = 0; i < 20; i++)
            send_frame(3, i < 16);
        wait_link_drain(20000);
        check_read("fill lo", REG_FIFO_SIZE_LO, 8'h10);
        check_read("fill hi", REG_FIFO_SIZE_HI, 8'h00);
        check_read("lost", REG_LOST_CNT, 8'h04);
        reader_on <= 1'b1;
        wait_expected_drained(2000);

        test_name = "rx_reset";
        reader_on <= 1'b0;
        send_frame(6, 1'b0);
        wait_link_drain(5000);
        check_read("fill before", REG_FIFO_SIZE_LO, 8'h02);
        bus_write(REG_RX_RST, 8'h00);
        wait_ready(1'b0, 20);
        check_read("status", REG_STATUS, 8'h06);
        check_read("fill lo", REG_FIFO_SIZE_LO, 8'h00);
        check_read("dec err", REG_DEC_ERR_CNT, 8'h00);
        check_read("lost", REG_LOST_CNT, 8'h00);
        check_reg("rx_reset fifo_empty", 8'h01, {7'd0, fifo_empty});
        reader_on <= 1'b1;
        wait_ready(1'b1, 2000);
        send_frame(9, 1'b1);
        wait_expected_drained(5000);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: compile.f
hdl/rx_cfg_pkg.sv
hdl/rx_data_pkg.sv
hdl/rx_symbol_aligner.sv
hdl/rx_8b10b_decoder.sv
hdl/rx_record_packer.sv
hdl/rx_record_fifo.sv
hdl/rx_bus_regs.sv
hdl/fei4_rx_top.sv
sim/tb_clock_gen.sv
sim/tb_fei4_rx.sv

// File: Bender.yml
package:
  name: fei4_rx

sources:
  - files:
      - hdl/rx_cfg_pkg.sv
      - hdl/rx_data_pkg.sv
      - hdl/rx_symbol_aligner.sv
      - hdl/rx_8b10b_decoder.sv
      - hdl/rx_record_packer.sv
      - hdl/rx_record_fifo.sv
      - hdl/rx_bus_regs.sv
      - hdl/fei4_rx_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_fei4_rx.sv
